// ==== matrix_pkg.sv ====
`default_nettype none

package matrix_pkg;

    // Digit and matrix geometry.
    localparam int unsigned digit_w = 3;
    localparam int unsigned matrix_n = 8;
    localparam int unsigned row_idx_w = 3;

    // Divisor defaults for a 50 MHz clock.
    localparam int unsigned scan_div_default = 50000;    // 1 kHz row rate.
    localparam int unsigned sec_div_default = 50000000;  // One tick per second.

    // Count loaded by the start pulse.
    localparam logic [digit_w-1:0] start_count = 3'd6;

    // Digits from red_limit upward are red, from yellow_limit upward yellow, below that green.
    localparam logic [digit_w-1:0] red_limit = 3'd4;
    localparam logic [digit_w-1:0] yellow_limit = 3'd2;

    // Colour codes. Bit 0 lights the red columns, bit 1 the green ones.
    localparam logic [1:0] colour_off = 2'b00;
    localparam logic [1:0] colour_red = 2'b01;
    localparam logic [1:0] colour_green = 2'b10;
    localparam logic [1:0] colour_yellow = 2'b11;

endpackage

`default_nettype wire

// ==== tick_gen.sv ====
`default_nettype none

module tick_gen #(
    parameter int unsigned DIV = 1000
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  restart,
    output logic tick
);

    localparam int unsigned cnt_w = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(DIV - 1);

    logic [cnt_w-1:0] cnt;

    assign tick = (cnt == cnt_last);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt <= '0;
        end
        else if (restart || tick)
        begin
            cnt <= '0; // A restart starts a full period from here.
        end
        else
        begin
            cnt <= cnt + cnt_w'(1);
        end
    end

    // Ticks are single pulses unless the divider is 1.
    tick_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        (DIV > 1) && tick |=> !tick
    );

endmodule

`default_nettype wire

// ==== countdown_ctrl.sv ====
`default_nettype none

module countdown_ctrl import matrix_pkg::*; (
    input  wire                clk,
    input  wire                rst,
    input  wire                st,
    input  wire                sec_tick,
    output logic [digit_w-1:0] digit,
    output logic               active,
    output logic               done
);

    typedef enum logic [1:0] {
        s_idle,
        s_counting,
        s_finished
    } state_t;

    state_t state;

    // Once started the digit stays on the matrix, also after the count has run out.
    assign active = (state != s_idle);
    assign done = (state == s_finished);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= s_idle;
            digit <= '0;
        end
        else if (st)
        begin
            state <= s_counting; // Start wins over a tick in the same cycle.
            digit <= start_count;
        end
        else if (state == s_counting && sec_tick && digit != '0)
        begin
            digit <= digit - digit_w'(1);
            if (digit == digit_w'(1))
            begin
                state <= s_finished;
            end
        end
    end

    // The digit only ever counts down from the loaded value.
    digit_in_range: assert property (
        @(posedge clk) disable iff (rst)
        digit <= start_count
    );

    // Finished means the zero glyph is being shown.
    done_at_zero: assert property (
        @(posedge clk) disable iff (rst)
        done |-> digit == '0
    );

endmodule

`default_nettype wire

// ==== glyph_rom.sv ====
`default_nettype none

module glyph_rom import matrix_pkg::*; (
    input  wire  [digit_w-1:0]   digit,
    input  wire  [row_idx_w-1:0] row_index,
    output logic [matrix_n-1:0]  glyph_r,
    output logic [matrix_n-1:0]  glyph_g
);

    logic [matrix_n-1:0] shape;
    logic [1:0]          colour;

    // Glyph bitmaps. Row 0 is left blank on every digit.
    always_comb
    begin
        shape = '0;
        case (digit)
            3'd6:
            begin
                case (row_index)
                    3'd1, 3'd7: shape = 8'b0011_1100;
                    3'd2:       shape = 8'b0110_0000;
                    3'd3:       shape = 8'b0111_1100;
                    3'd4, 3'd5,
                    3'd6:       shape = 8'b0110_0110;
                    default:    shape = '0;
                endcase
            end
            3'd5:
            begin
                case (row_index)
                    3'd1:       shape = 8'b0111_1110;
                    3'd2:       shape = 8'b0110_0000;
                    3'd3:       shape = 8'b0111_1100;
                    3'd4, 3'd5: shape = 8'b0000_0110;
                    3'd6:       shape = 8'b0110_0110;
                    3'd7:       shape = 8'b0011_1100;
                    default:    shape = '0;
                endcase
            end
            3'd4:
            begin
                case (row_index)
                    3'd1, 3'd6,
                    3'd7:       shape = 8'b0000_1100;
                    3'd2:       shape = 8'b0001_1100;
                    3'd3:       shape = 8'b0010_1100;
                    3'd4:       shape = 8'b0100_1100;
                    3'd5:       shape = 8'b0111_1110; // Crossbar of the 4.
                    default:    shape = '0;
                endcase
            end
            3'd3:
            begin
                case (row_index)
                    3'd1, 3'd7: shape = 8'b0011_1100;
                    3'd2, 3'd6: shape = 8'b0110_0110;
                    3'd3, 3'd5: shape = 8'b0000_0110;
                    3'd4:       shape = 8'b0001_1100;
                    default:    shape = '0;
                endcase
            end
            3'd2:
            begin
                case (row_index)
                    3'd1:       shape = 8'b0011_1100;
                    3'd2:       shape = 8'b0110_0110;
                    3'd3:       shape = 8'b0000_0110;
                    3'd4:       shape = 8'b0000_1100;
                    3'd5:       shape = 8'b0011_0000;
                    3'd6:       shape = 8'b0110_0000;
                    3'd7:       shape = 8'b0111_1110;
                    default:    shape = '0;
                endcase
            end
            3'd1:
            begin
                case (row_index)
                    3'd1, 3'd2, 3'd4,
                    3'd5, 3'd6: shape = 8'b0001_1000;
                    3'd3:       shape = 8'b0011_1000;
                    3'd7:       shape = 8'b0111_1110; // Foot of the 1.
                    default:    shape = '0;
                endcase
            end
            3'd0:
            begin
                case (row_index)
                    3'd1, 3'd7: shape = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4,
                    3'd5, 3'd6: shape = 8'b0100_0010;
                    default:    shape = '0;
                endcase
            end
            default:
            begin
                shape = '0;
            end
        endcase
    end

    // Colour by urgency.
    always_comb
    begin
        if (digit > start_count)
        begin
            colour = colour_off;
        end
        else if (digit >= red_limit)
        begin
            colour = colour_red;
        end
        else if (digit >= yellow_limit)
        begin
            colour = colour_yellow; // Red and green together.
        end
        else
        begin
            colour = colour_green;
        end
    end

    assign glyph_r = shape & {matrix_n{colour[0]}};
    assign glyph_g = shape & {matrix_n{colour[1]}};

endmodule

`default_nettype wire

// ==== matrix_scan.sv ====
`default_nettype none

module matrix_scan import matrix_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  scan_tick,
    input  wire                  active,
    input  wire  [matrix_n-1:0]  glyph_r,
    input  wire  [matrix_n-1:0]  glyph_g,
    output logic [row_idx_w-1:0] row_index,
    output logic [matrix_n-1:0]  row,
    output logic [matrix_n-1:0]  colr,
    output logic [matrix_n-1:0]  colg
);

    logic [row_idx_w-1:0] row_cnt;

    // The table is looked up for the row that the next tick selects, so
    // row and columns are loaded together on the same edge.
    assign row_index = row_cnt + row_idx_w'(1); // Wraps from 7 to 0.

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt <= row_idx_w'(matrix_n - 1); // First tick selects row 0.
        end
        else if (scan_tick)
        begin
            row_cnt <= row_index;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row <= '1;
            colr <= '0;
            colg <= '0;
        end
        else if (scan_tick)
        begin
            row <= ~(matrix_n'(1) << row_index); // Rows are active low.
            colr <= active ? glyph_r : '0;
            colg <= active ? glyph_g : '0;
        end
    end

    // At most one row is driven at a time.
    row_one_cold: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(~row) || (&row)
    );

endmodule

`default_nettype wire

// ==== countdown_matrix_top.sv ====
`default_nettype none

module countdown_matrix_top import matrix_pkg::*; #(
    parameter int unsigned SCAN_DIV = scan_div_default,
    parameter int unsigned SEC_DIV = sec_div_default
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 st,
    output logic [matrix_n-1:0] row,
    output logic [matrix_n-1:0] colr,
    output logic [matrix_n-1:0] colg,
    output logic                done
);

    logic                 scan_tick;
    logic                 sec_tick;
    logic [digit_w-1:0]   digit;
    logic                 active;
    logic [row_idx_w-1:0] row_index;
    logic [matrix_n-1:0]  glyph_r;
    logic [matrix_n-1:0]  glyph_g;

    tick_gen #(
        .DIV(SCAN_DIV)
    ) u_scan_tick (
        .clk    (clk),
        .rst    (rst),
        .restart(1'b0),
        .tick   (scan_tick)
    );

    // Seconds are counted from the start press.
    tick_gen #(
        .DIV(SEC_DIV)
    ) u_sec_tick (
        .clk    (clk),
        .rst    (rst),
        .restart(st),
        .tick   (sec_tick)
    );

    countdown_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .sec_tick(sec_tick),
        .digit   (digit),
        .active  (active),
        .done    (done)
    );

    glyph_rom u_glyph (
        .digit    (digit),
        .row_index(row_index),
        .glyph_r  (glyph_r),
        .glyph_g  (glyph_g)
    );

    matrix_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .scan_tick(scan_tick),
        .active   (active),
        .glyph_r  (glyph_r),
        .glyph_g  (glyph_g),
        .row_index(row_index),
        .row      (row),
        .colr     (colr),
        .colg     (colg)
    );

endmodule

`default_nettype wire

// ==== tb_glyph_table.svh ====
`ifndef TB_GLYPH_TABLE_SVH
`define TB_GLYPH_TABLE_SVH

// Each word holds rows 0 to 7 of one digit, row 0 in the top byte.
function automatic logic [7:0] glyph_row(input int unsigned d, input int unsigned r);
    logic [63:0] bits;
    case (d)
        6:       bits = 64'h003C_607C_6666_663C;
        5:       bits = 64'h007E_607C_0606_663C;
        4:       bits = 64'h000C_1C2C_4C7E_0C0C;
        3:       bits = 64'h003C_6606_1C06_663C;
        2:       bits = 64'h003C_6606_0C30_607E;
        1:       bits = 64'h0018_1838_1818_187E;
        0:       bits = 64'h003C_4242_4242_423C;
        default: bits = '0;
    endcase
    return bits[63 - 8 * r -: 8];
endfunction

// Urgency colour of each digit.
function automatic logic [1:0] glyph_colour(input int unsigned d);
    case (d)
        6, 5, 4: return colour_red;
        3, 2:    return colour_yellow; // Both colours lit.
        1, 0:    return colour_green;
        default: return colour_off;
    endcase
endfunction

function automatic logic [7:0] expected_red(input int unsigned d, input int unsigned r);
    logic [1:0] c;
    c = glyph_colour(d);
    return glyph_row(d, r) & {8{c[0]}};
endfunction

function automatic logic [7:0] expected_green(input int unsigned d, input int unsigned r);
    logic [1:0] c;
    c = glyph_colour(d);
    return glyph_row(d, r) & {8{c[1]}};
endfunction

`endif

// ==== tb_countdown_matrix.sv ====
`default_nettype none

module tb_countdown_matrix import matrix_pkg::*;;

    localparam int unsigned scan_div = 4;
    localparam int unsigned sec_div = 64;  // Two full frames per second.
    localparam int n_entries = 5;

    logic                clk;
    logic                rst;
    logic                st;
    wire  [matrix_n-1:0] row;
    wire  [matrix_n-1:0] colr;
    wire  [matrix_n-1:0] colg;
    wire                 done;

    int unsigned wait_len [0:n_entries-1];
    bit          pulse_st [0:n_entries-1];
    bit          table_ready;
    integer      seed;
    int unsigned wait_now;
    int unsigned wd_limit;
    int          checks;
    int          errors;
    int          i;

    // Reference model of the countdown.
    logic [digit_w-1:0] model_digit;
    logic [digit_w-1:0] pre_digit;  // Columns loaded at an edge show the digit from before it.
    logic               model_active;
    logic               pre_active;
    logic               model_done;
    int unsigned        sec_cnt;

    // Monitor state.
    logic [matrix_n-1:0] last_row;
    logic [matrix_n-1:0] last_colr;
    logic [matrix_n-1:0] last_colg;
    logic [matrix_n-1:0] exp_r;
    logic [matrix_n-1:0] exp_g;
    int unsigned         last_idx;
    int unsigned         row_idx;
    int unsigned         zeros;
    int unsigned         gap;
    int unsigned         row_changes;
    logic [6:0]          shown_mask;
    int                  bit_i;

    `include "tb_glyph_table.svh"

    countdown_matrix_top #(
        .SCAN_DIV(scan_div),
        .SEC_DIV (sec_div)
    ) uut (
        .clk (clk),
        .rst (rst),
        .st  (st),
        .row (row),
        .colr(colr),
        .colg(colg),
        .done(done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("FAIL %s: actual 0x%h expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic load_table();
        wait_len[0] = 30; // Blank matrix before any start.
        pulse_st[0] = 1'b0;
        wait_len[1] = 4; // First start.
        pulse_st[1] = 1'b1;
        wait_len[2] = 150; // Restart while 4 is shown.
        pulse_st[2] = 1'b1;
        wait_len[3] = 470; // Run down to 0 and hold.
        pulse_st[3] = 1'b0;
        wait_len[4] = 40;
        pulse_st[4] = 1'b0;
    endtask

    assign model_done = model_active && (model_digit == '0);

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            model_digit <= '0;
            model_active <= 1'b0;
            pre_digit <= '0;
            pre_active <= 1'b0;
            sec_cnt <= 0;
        end
        else
        begin
            pre_digit <= model_digit;
            pre_active <= model_active;
            if (st)
            begin
                model_digit <= start_count;
                model_active <= 1'b1;
                sec_cnt <= 0;
            end
            else if (model_active)
            begin
                if (sec_cnt == sec_div - 1)
                begin
                    sec_cnt <= 0;
                    if (model_digit != '0)
                        model_digit <= model_digit - 1'b1;
                end
                else
                begin
                    sec_cnt <= sec_cnt + 1;
                end
            end
        end
    end

    // Outputs are sampled on the falling edge, half a cycle after they settle.
    always @(negedge clk)
    begin
        if (!rst)
        begin
            gap = gap + 1;
            check_value("done", done, model_done);
            if (row !== last_row)
            begin
                zeros = 0;
                for (bit_i = 0; bit_i < matrix_n; bit_i++)
                begin
                    if (row[bit_i] === 1'b0)
                    begin
                        zeros++;
                        row_idx = bit_i;
                    end
                end
                check_value("row zero bits", zeros, 1);
                check_value("row index", row_idx, (last_idx + 1) % matrix_n);
                // The first tick comes scan_div edges after reset, one falling edge after counting starts.
                if (row_changes > 0)
                    check_value("row period", gap, scan_div);
                else
                    check_value("first row delay", gap, scan_div + 1);
                exp_r = pre_active ? expected_red(pre_digit, row_idx) : 8'h00;
                exp_g = pre_active ? expected_green(pre_digit, row_idx) : 8'h00;
                check_value("colr", colr, exp_r);
                check_value("colg", colg, exp_g);
                // A digit counts as shown once one of its lit rows has appeared correctly.
                if (pre_active && (exp_r | exp_g) != 8'h00 && colr === exp_r && colg === exp_g)
                    shown_mask[pre_digit] = 1'b1;
                last_idx = row_idx;
                row_changes++;
                gap = 0;
            end
            else
            begin
                check_value("colr hold", colr, last_colr);
                check_value("colg hold", colg, last_colg);
                if (gap == 2 * scan_div)
                    check_value("row period", gap, scan_div);
            end
            last_row = row;
            last_colr = colr;
            last_colg = colg;
        end
    end

    initial
    begin
        wait (table_ready);
        wd_limit = 3 + 200 + 2;
        for (int k = 0; k < n_entries; k++)
            wd_limit += wait_len[k] + 7 + 1;
        repeat (wd_limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles without the test sequence ending.", wd_limit);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        rst = 1'b1;
        st = 1'b0;
        seed = 70;
        checks = 0;
        errors = 0;
        last_row = '1;
        last_colr = '0;
        last_colg = '0;
        last_idx = matrix_n - 1;
        gap = 0;
        row_changes = 0;
        shown_mask = '0;
        load_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        for (i = 0; i < n_entries; i++)
        begin
            wait_now = wait_len[i] + ($unsigned($random(seed)) % 8);
            repeat (wait_now) @(posedge clk);
            if (pulse_st[i])
            begin
                #1 st = 1'b1;
                @(posedge clk);
                #1 st = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        check_value("digits shown", shown_mask, 7'h7F);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
matrix_pkg.sv
tick_gen.sv
countdown_ctrl.sv
glyph_rom.sv
matrix_scan.sv
countdown_matrix_top.sv
tb_countdown_matrix.sv
